// File: src/axi_mem_settings.svh
/*
 * AXI memory subordinate settings
 * Bus widths, RAM depth and the depth of the AW and AR queues
 */

`ifndef AXI_MEM_SETTINGS_SVH
`define AXI_MEM_SETTINGS_SVH

// Byte address width of AW and AR
`define AXI_MEM_ADDR_WIDTH 16

// Data bus width, one RAM word per beat
`define AXI_MEM_DATA_WIDTH 32

// Transaction ID width
`define AXI_MEM_ID_WIDTH 4

// RAM depth in words
// Addresses beyond this wrap around
`define AXI_MEM_WORDS 1024

// Entries per address queue
`define AXI_MEM_FIFO_DEPTH 4

`endif

// File: src/axi_mem_pkg.sv
/*
 * AXI memory subordinate types
 * Burst and response codes, channel payloads and the request/response structs
 */

`include "axi_mem_settings.svh"

package axi_mem_pkg;

  // Basic field types
  typedef logic [`AXI_MEM_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`AXI_MEM_DATA_WIDTH-1:0]   data_t;
  typedef logic [`AXI_MEM_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [`AXI_MEM_ID_WIDTH-1:0]     id_t;
  typedef logic [$clog2(`AXI_MEM_WORDS)-1:0] word_idx_t;

  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_t;

  // Only OKAY is ever returned
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_t;

  // Shared by AW and AR
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    data_t data;
    id_t   id;
    resp_t resp;
    logic  last;
  } r_chan_t;

  // Manager to subordinate
  typedef struct packed {
    ax_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ax_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Subordinate to manager
  typedef struct packed {
    logic    aw_ready;
    logic    ar_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    r_chan_t r;
    logic    r_valid;
  } axi_rsp_t;

endpackage

// File: src/axi_beat_addr.sv
/*
 * AXI beat address generator
 * Combinational next-beat address for FIXED, INCR and WRAP bursts
 */

module axi_beat_addr (
  input  axi_mem_pkg::addr_t  addr_i,
  input  axi_mem_pkg::len_t   len_i,
  input  axi_mem_pkg::size_t  size_i,
  input  axi_mem_pkg::burst_t burst_i,
  output axi_mem_pkg::addr_t  next_addr_o
);

  axi_mem_pkg::addr_t beat_bytes;
  axi_mem_pkg::addr_t aligned_addr;
  axi_mem_pkg::addr_t incr_addr;
  axi_mem_pkg::addr_t wrap_mask;

  assign beat_bytes = axi_mem_pkg::addr_t'(1) << size_i;

  // Align down to the beat size, then step one beat
  assign aligned_addr = addr_i & ~(beat_bytes - axi_mem_pkg::addr_t'(1));
  assign incr_addr    = aligned_addr + beat_bytes;

  // Window is beat size times beat count, a power of two for legal WRAP lengths
  assign wrap_mask = ((axi_mem_pkg::addr_t'(len_i) + axi_mem_pkg::addr_t'(1)) << size_i)
                     - axi_mem_pkg::addr_t'(1);

  always_comb begin
    case (burst_i)
      axi_mem_pkg::BURST_FIXED: begin
        next_addr_o = addr_i;
      end
      axi_mem_pkg::BURST_INCR: begin
        next_addr_o = incr_addr;
      end
      axi_mem_pkg::BURST_WRAP: begin
        // Upper bits stay in the window, lower bits roll over
        next_addr_o = (addr_i & ~wrap_mask) | (incr_addr & wrap_mask);
      end
      default: begin
        // Reserved burst type treated as FIXED
        next_addr_o = addr_i;
      end
    endcase
  end

endmodule

// File: src/axi_addr_fifo.sv
/*
 * Address channel FIFO
 * Circular buffer that queues AW or AR requests for the data paths
 */

module axi_addr_fifo #(
  parameter type         ax_t  = logic,
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic push_i,
  input  ax_t  data_i,
  output logic full_o,
  input  logic pop_i,
  output ax_t  data_o,
  output logic empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  ax_t              mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Upstream must honour ready, the data path must honour the level
  assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o)
    else $error("push into full address FIFO");
  assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o)
    else $error("pop from empty address FIFO");

endmodule

// File: src/axi_mem_array.sv
/*
 * Memory array
 * Word RAM with a byte-strobed write port and a registered read port
 */

`include "axi_mem_settings.svh"

module axi_mem_array (
  input  logic                   clk_i,
  input  logic                   we_i,
  input  axi_mem_pkg::word_idx_t waddr_i,
  input  axi_mem_pkg::data_t     wdata_i,
  input  axi_mem_pkg::strb_t     wbe_i,
  input  logic                   re_i,
  input  axi_mem_pkg::word_idx_t raddr_i,
  output axi_mem_pkg::data_t     rdata_o
);

  localparam int unsigned STRB_W = $bits(axi_mem_pkg::strb_t);

  axi_mem_pkg::data_t mem_q [`AXI_MEM_WORDS];

  // Only lanes with their strobe set are updated
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wbe_i[b]) begin
          mem_q[waddr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Read data holds until the next read-enable
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem_q[raddr_i];
    end
  end

endmodule

// File: src/axi_mem_write.sv
/*
 * AXI write path
 * Walks each W burst into the RAM at the queued AW address and returns B
 */

module axi_mem_write (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  axi_mem_pkg::ax_chan_t  aw_i,
  input  logic                   aw_empty_i,
  output logic                   aw_pop_o,
  input  axi_mem_pkg::w_chan_t   w_i,
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  output axi_mem_pkg::b_chan_t   b_o,
  output logic                   b_valid_o,
  input  logic                   b_ready_i,
  output logic                   we_o,
  output axi_mem_pkg::word_idx_t waddr_o,
  output axi_mem_pkg::data_t     wdata_o,
  output axi_mem_pkg::strb_t     wbe_o
);

  localparam int unsigned OFF_W = $clog2($bits(axi_mem_pkg::strb_t));
  localparam int unsigned IDX_W = $bits(axi_mem_pkg::word_idx_t);

  axi_mem_pkg::len_t  beat_cnt_q;
  logic               in_burst_q;
  axi_mem_pkg::addr_t cur_addr_q;
  axi_mem_pkg::addr_t beat_addr;
  axi_mem_pkg::addr_t next_addr;
  logic               b_valid_q;
  axi_mem_pkg::id_t   b_id_q;
  logic               w_hs;
  logic               last_beat;

  // First beat takes the AW address directly
  assign beat_addr = in_burst_q ? cur_addr_q : aw_i.addr;
  assign last_beat = (beat_cnt_q == aw_i.len);

  // Stall W while a response is still pending
  assign w_ready_o = !aw_empty_i && !b_valid_q;
  assign w_hs      = w_valid_i && w_ready_o;
  assign aw_pop_o  = w_hs && last_beat;

  axi_beat_addr i_beat_addr (
    .addr_i      (beat_addr),
    .len_i       (aw_i.len),
    .size_i      (aw_i.size),
    .burst_i     (aw_i.burst),
    .next_addr_o (next_addr)
  );

  assign we_o    = w_hs;
  assign waddr_o = beat_addr[OFF_W +: IDX_W];
  assign wdata_o = w_i.data;
  assign wbe_o   = w_i.strb;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      beat_cnt_q <= '0;
      in_burst_q <= 1'b0;
      b_valid_q  <= 1'b0;
    end else begin
      if (w_hs) begin
        beat_cnt_q <= last_beat ? '0 : beat_cnt_q + 1'b1;
        in_burst_q <= !last_beat;
      end
      if (aw_pop_o) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_hs && !last_beat) begin
      cur_addr_q <= next_addr;
    end
    if (aw_pop_o) begin
      b_id_q <= aw_i.id;
    end
  end

  assign b_o.id    = b_id_q;
  assign b_o.resp  = axi_mem_pkg::RESP_OKAY;
  assign b_valid_o = b_valid_q;

  // Manager's WLAST must agree with the AW length
  assert property (@(posedge clk_i) disable iff (!rst_n_i) w_hs |-> (w_i.last == last_beat))
    else $error("WLAST does not match AWLEN");

endmodule

// File: src/axi_mem_read.sv
/*
 * AXI read path
 * Walks each queued AR burst out of the RAM, one read in flight,
 * and presents the beats on R through an output register
 */

module axi_mem_read (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  axi_mem_pkg::ax_chan_t  ar_i,
  input  logic                   ar_empty_i,
  output logic                   ar_pop_o,
  output logic                   re_o,
  output axi_mem_pkg::word_idx_t raddr_o,
  input  axi_mem_pkg::data_t     rdata_i,
  output axi_mem_pkg::r_chan_t   r_o,
  output logic                   r_valid_o,
  input  logic                   r_ready_i
);

  localparam int unsigned OFF_W = $clog2($bits(axi_mem_pkg::strb_t));
  localparam int unsigned IDX_W = $bits(axi_mem_pkg::word_idx_t);

  axi_mem_pkg::len_t    beat_cnt_q;
  logic                 in_burst_q;
  axi_mem_pkg::addr_t   cur_addr_q;
  axi_mem_pkg::addr_t   beat_addr;
  axi_mem_pkg::addr_t   next_addr;
  logic                 last_beat;
  logic                 inflight_q;
  axi_mem_pkg::id_t     inflight_id_q;
  logic                 inflight_last_q;
  logic                 r_valid_q;
  axi_mem_pkg::r_chan_t r_q;
  logic                 out_free;
  logic                 issue;
  logic                 move;

  assign beat_addr = in_burst_q ? cur_addr_q : ar_i.addr;
  assign last_beat = (beat_cnt_q == ar_i.len);

  // Output register empty or being taken this cycle
  assign out_free = !r_valid_q || r_ready_i;
  // RAM data register doubles as the in-flight slot
  assign move     = inflight_q && out_free;
  assign issue    = !ar_empty_i && out_free;
  assign ar_pop_o = issue && last_beat;

  axi_beat_addr i_beat_addr (
    .addr_i      (beat_addr),
    .len_i       (ar_i.len),
    .size_i      (ar_i.size),
    .burst_i     (ar_i.burst),
    .next_addr_o (next_addr)
  );

  assign re_o    = issue;
  assign raddr_o = beat_addr[OFF_W +: IDX_W];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      beat_cnt_q <= '0;
      in_burst_q <= 1'b0;
      inflight_q <= 1'b0;
      r_valid_q  <= 1'b0;
    end else begin
      if (issue) begin
        beat_cnt_q <= last_beat ? '0 : beat_cnt_q + 1'b1;
        in_burst_q <= !last_beat;
      end
      if (issue) begin
        inflight_q <= 1'b1;
      end else if (move) begin
        inflight_q <= 1'b0;
      end
      if (move) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue && !last_beat) begin
      cur_addr_q <= next_addr;
    end
    if (issue) begin
      inflight_id_q   <= ar_i.id;
      inflight_last_q <= last_beat;
    end
    if (move) begin
      r_q.data <= rdata_i;
      r_q.id   <= inflight_id_q;
      r_q.resp <= axi_mem_pkg::RESP_OKAY;
      r_q.last <= inflight_last_q;
    end
  end

  assign r_o       = r_q;
  assign r_valid_o = r_valid_q;

  // A stalled beat must not change or vanish
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
    else $error("R changed while stalled");

endmodule

// File: src/axi_mem_top.sv
/*
 * AXI4 memory subordinate
 * Address queues feed a write path and a read path around one RAM
 */

`include "axi_mem_settings.svh"

module axi_mem_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  axi_mem_pkg::axi_req_t axi_req_i,
  output axi_mem_pkg::axi_rsp_t axi_rsp_o
);

  axi_mem_pkg::ax_chan_t  aw_head;
  axi_mem_pkg::ax_chan_t  ar_head;
  logic                   aw_full;
  logic                   aw_empty;
  logic                   aw_pop;
  logic                   ar_full;
  logic                   ar_empty;
  logic                   ar_pop;
  logic                   w_ready;
  axi_mem_pkg::b_chan_t   b;
  logic                   b_valid;
  axi_mem_pkg::r_chan_t   r;
  logic                   r_valid;
  logic                   we;
  axi_mem_pkg::word_idx_t waddr;
  axi_mem_pkg::data_t     wdata;
  axi_mem_pkg::strb_t     wbe;
  logic                   re;
  axi_mem_pkg::word_idx_t raddr;
  axi_mem_pkg::data_t     rdata;

  axi_addr_fifo #(
    .ax_t  (axi_mem_pkg::ax_chan_t),
    .DEPTH (`AXI_MEM_FIFO_DEPTH)
  ) i_aw_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (axi_req_i.aw_valid && !aw_full),
    .data_i  (axi_req_i.aw),
    .full_o  (aw_full),
    .pop_i   (aw_pop),
    .data_o  (aw_head),
    .empty_o (aw_empty)
  );

  axi_addr_fifo #(
    .ax_t  (axi_mem_pkg::ax_chan_t),
    .DEPTH (`AXI_MEM_FIFO_DEPTH)
  ) i_ar_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (axi_req_i.ar_valid && !ar_full),
    .data_i  (axi_req_i.ar),
    .full_o  (ar_full),
    .pop_i   (ar_pop),
    .data_o  (ar_head),
    .empty_o (ar_empty)
  );

  axi_mem_write i_write (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .aw_i       (aw_head),
    .aw_empty_i (aw_empty),
    .aw_pop_o   (aw_pop),
    .w_i        (axi_req_i.w),
    .w_valid_i  (axi_req_i.w_valid),
    .w_ready_o  (w_ready),
    .b_o        (b),
    .b_valid_o  (b_valid),
    .b_ready_i  (axi_req_i.b_ready),
    .we_o       (we),
    .waddr_o    (waddr),
    .wdata_o    (wdata),
    .wbe_o      (wbe)
  );

  axi_mem_read i_read (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ar_i       (ar_head),
    .ar_empty_i (ar_empty),
    .ar_pop_o   (ar_pop),
    .re_o       (re),
    .raddr_o    (raddr),
    .rdata_i    (rdata),
    .r_o        (r),
    .r_valid_o  (r_valid),
    .r_ready_i  (axi_req_i.r_ready)
  );

  axi_mem_array i_array (
    .clk_i   (clk_i),
    .we_i    (we),
    .waddr_i (waddr),
    .wdata_i (wdata),
    .wbe_i   (wbe),
    .re_i    (re),
    .raddr_i (raddr),
    .rdata_o (rdata)
  );

  // Address readies are the queues' free space
  assign axi_rsp_o = '{
    aw_ready: !aw_full,
    ar_ready: !ar_full,
    w_ready:  w_ready,
    b:        b,
    b_valid:  b_valid,
    r:        r,
    r_valid:  r_valid
  };

endmodule

// File: verif/tb_axi_mem.sv
/*
 * Testbench for the AXI4 memory subordinate
 * Drives write and read bursts, keeps a byte model of the RAM and
 * checks B and R against it, with stalls on the response channels
 */

`include "axi_mem_settings.svh"

module tb_axi_mem;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned BYTES_PER_WORD = `AXI_MEM_DATA_WIDTH / 8;

  // Watchdog budget from the test lengths and their stalls
  localparam int unsigned MAX_BEATS       = 100;
  localparam int unsigned MAX_TXNS        = 20;
  localparam int unsigned CYCLES_PER_BEAT = 4;
  localparam int unsigned TXN_OVERHEAD    = 8;
  localparam int unsigned RUN_CYCLES      = 16 + MAX_BEATS * CYCLES_PER_BEAT
                                            + MAX_TXNS * TXN_OVERHEAD;
  localparam int unsigned WATCHDOG_NS     = RUN_CYCLES * 10 * 4;

  logic                  clk = 1'b0;
  logic                  rst_n;
  axi_mem_pkg::axi_req_t axi_req;
  axi_mem_pkg::axi_rsp_t axi_rsp;
  logic [4:0]            rsp_flags;

  logic [7:0]            model_mem [`AXI_MEM_WORDS * BYTES_PER_WORD];
  axi_mem_pkg::data_t    wdata_buf [16];
  axi_mem_pkg::strb_t    wstrb_buf [16];
  logic [31:0]           rand_state = 32'd18;

  string                 cur_test;
  int                    errors = 0;
  int                    test_err_base = 0;
  int                    tests_run = 0;
  int                    tests_bad = 0;

  always #5 clk = ~clk;

  axi_mem_top UUT (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .axi_req_i (axi_req),
    .axi_rsp_o (axi_rsp)
  );

  assign rsp_flags = {axi_rsp.aw_ready, axi_rsp.ar_ready, axi_rsp.w_ready,
                      axi_rsp.b_valid, axi_rsp.r_valid};

  // Ready/valid state right as reset is released
  assert property (@(posedge clk) $rose(rst_n) |-> rsp_flags == 5'b11000)
    else begin
      errors = errors + 1;
      $display("CHECK FAILED %s reset flags: expected 11000, actual %b",
               cur_test, $sampled(rsp_flags));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
                   axi_rsp.b_valid && !axi_req.b_ready |=> axi_rsp.b_valid && $stable(axi_rsp.b))
    else begin
      errors = errors + 1;
      $display("CHECK FAILED %s: B was dropped or changed while stalled", cur_test);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
                   axi_rsp.r_valid && !axi_req.r_ready |=> axi_rsp.r_valid && $stable(axi_rsp.r))
    else begin
      errors = errors + 1;
      $display("CHECK FAILED %s: R beat was dropped or changed while stalled", cur_test);
    end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state;
  endfunction

  function automatic axi_mem_pkg::ax_chan_t make_ax(int id, int addr, int len, int size,
                                                    axi_mem_pkg::burst_t burst);
    axi_mem_pkg::ax_chan_t ax;
    ax.id    = axi_mem_pkg::id_t'(id);
    ax.addr  = axi_mem_pkg::addr_t'(addr);
    ax.len   = axi_mem_pkg::len_t'(len);
    ax.size  = axi_mem_pkg::size_t'(size);
    ax.burst = burst;
    return ax;
  endfunction

  // Address of a beat from the start of the burst
  function automatic axi_mem_pkg::addr_t beat_address(axi_mem_pkg::ax_chan_t ax, int beat);
    int unsigned bytes;
    int unsigned start;
    int unsigned aligned;
    int unsigned window;
    int unsigned base;
    bytes   = 1 << ax.size;
    start   = ax.addr;
    aligned = start - (start % bytes);
    if (beat == 0 || ax.burst == axi_mem_pkg::BURST_FIXED) begin
      return ax.addr;
    end
    if (ax.burst == axi_mem_pkg::BURST_WRAP) begin
      window = bytes * (int'(ax.len) + 1);
      base   = start - (start % window);
      return axi_mem_pkg::addr_t'(base + (aligned - base + beat * bytes) % window);
    end
    return axi_mem_pkg::addr_t'(aligned + beat * bytes);
  endfunction

  // Addresses past the RAM wrap around
  function automatic int unsigned byte_index(axi_mem_pkg::addr_t a, int lane);
    return ((a / BYTES_PER_WORD) % `AXI_MEM_WORDS) * BYTES_PER_WORD + lane;
  endfunction

  function automatic axi_mem_pkg::data_t model_word(axi_mem_pkg::addr_t a);
    axi_mem_pkg::data_t w;
    for (int lane = 0; lane < BYTES_PER_WORD; lane++) begin
      w[lane*8 +: 8] = model_mem[byte_index(a, lane)];
    end
    return w;
  endfunction

  task automatic flag_mismatch(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    errors = errors + 1;
    $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = errors;
  endtask

  task automatic end_test();
    tests_run = tests_run + 1;
    if (errors == test_err_base) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_bad = tests_bad + 1;
      $display("test %s: FAIL with %0d errors", cur_test, errors - test_err_base);
    end
  endtask

  task automatic fill_buf(input int beats, input axi_mem_pkg::strb_t strb);
    for (int i = 0; i < beats; i++) begin
      wdata_buf[i] = next_rand();
      wstrb_buf[i] = strb;
    end
  endtask

  // Sends AW and the buffered W beats, then waits for B
  task automatic send_write(input axi_mem_pkg::ax_chan_t ax, input logic stall);
    axi_mem_pkg::addr_t a;
    logic               acc;
    logic [31:0]        r;
    axi_req.aw       = ax;
    axi_req.aw_valid = 1'b1;
    do begin
      acc = axi_rsp.aw_ready;
      @(negedge clk);
    end while (!acc);
    axi_req.aw_valid = 1'b0;
    for (int beat = 0; beat <= int'(ax.len); beat++) begin
      a = beat_address(ax, beat);
      for (int lane = 0; lane < BYTES_PER_WORD; lane++) begin
        if (wstrb_buf[beat][lane]) begin
          model_mem[byte_index(a, lane)] = wdata_buf[beat][lane*8 +: 8];
        end
      end
      axi_req.w.data  = wdata_buf[beat];
      axi_req.w.strb  = wstrb_buf[beat];
      axi_req.w.last  = (beat == int'(ax.len));
      axi_req.w_valid = 1'b1;
      do begin
        acc = axi_rsp.w_ready;
        @(negedge clk);
      end while (!acc);
    end
    axi_req.w_valid = 1'b0;
    do begin
      r = next_rand();
      axi_req.b_ready = stall ? r[16] : 1'b1;
      acc = axi_rsp.b_valid && axi_req.b_ready;
      if (acc) begin
        assert (axi_rsp.b.id == ax.id) else flag_mismatch("B id", ax.id, axi_rsp.b.id);
        assert (axi_rsp.b.resp == axi_mem_pkg::RESP_OKAY)
          else flag_mismatch("B resp", axi_mem_pkg::RESP_OKAY, axi_rsp.b.resp);
      end
      @(negedge clk);
    end while (!acc);
    axi_req.b_ready = 1'b0;
  endtask

  task automatic send_ar(input axi_mem_pkg::ax_chan_t ax);
    logic acc;
    axi_req.ar       = ax;
    axi_req.ar_valid = 1'b1;
    do begin
      acc = axi_rsp.ar_ready;
      @(negedge clk);
    end while (!acc);
    axi_req.ar_valid = 1'b0;
  endtask

  // Beats are taken at the falling edge while R is settled
  task automatic collect_r(input axi_mem_pkg::ax_chan_t ax, input logic stall);
    int                 beat;
    logic               acc;
    logic [31:0]        r;
    axi_mem_pkg::data_t exp;
    beat = 0;
    while (beat <= int'(ax.len)) begin
      r = next_rand();
      axi_req.r_ready = stall ? r[16] : 1'b1;
      acc = axi_rsp.r_valid && axi_req.r_ready;
      if (acc) begin
        exp = model_word(beat_address(ax, beat));
        assert (axi_rsp.r.data === exp) else flag_mismatch("R data", exp, axi_rsp.r.data);
        assert (axi_rsp.r.id == ax.id) else flag_mismatch("R id", ax.id, axi_rsp.r.id);
        assert (axi_rsp.r.last == (beat == int'(ax.len)))
          else flag_mismatch("R last", (beat == int'(ax.len)), axi_rsp.r.last);
        assert (axi_rsp.r.resp == axi_mem_pkg::RESP_OKAY)
          else flag_mismatch("R resp", axi_mem_pkg::RESP_OKAY, axi_rsp.r.resp);
        beat = beat + 1;
      end
      @(negedge clk);
    end
    axi_req.r_ready = 1'b0;
  endtask

  task automatic read_burst(input axi_mem_pkg::ax_chan_t ax, input logic stall);
    send_ar(ax);
    collect_r(ax, stall);
  endtask

  initial begin
    axi_mem_pkg::ax_chan_t ax;
    axi_mem_pkg::ax_chan_t ars [3];
    axi_mem_pkg::addr_t    a;
    axi_req = '0;
    rst_n   = 1'b0;

    start_test("reset");
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    end_test();

    start_test("incr");
    fill_buf(8, 4'hF);
    send_write(make_ax(3, 'h0040, 7, 2, axi_mem_pkg::BURST_INCR), 1'b0);
    read_burst(make_ax(5, 'h0040, 7, 2, axi_mem_pkg::BURST_INCR), 1'b0);
    end_test();

    start_test("wrap_fixed");
    fill_buf(4, 4'hF);
    send_write(make_ax(6, 'h0108, 3, 2, axi_mem_pkg::BURST_WRAP), 1'b0);
    read_burst(make_ax(6, 'h0100, 3, 2, axi_mem_pkg::BURST_INCR), 1'b0);
    read_burst(make_ax(7, 'h0108, 3, 2, axi_mem_pkg::BURST_WRAP), 1'b0);
    // All four beats hit one word
    fill_buf(4, 4'hF);
    send_write(make_ax(8, 'h0200, 3, 2, axi_mem_pkg::BURST_FIXED), 1'b0);
    read_burst(make_ax(9, 'h0200, 0, 2, axi_mem_pkg::BURST_INCR), 1'b0);
    read_burst(make_ax(2, 'h0200, 1, 2, axi_mem_pkg::BURST_FIXED), 1'b0);
    end_test();

    start_test("strobes");
    fill_buf(4, 4'hF);
    send_write(make_ax(1, 'h0300, 3, 2, axi_mem_pkg::BURST_INCR), 1'b0);
    fill_buf(4, 4'hF);
    wstrb_buf[0] = 4'b0101;
    wstrb_buf[1] = 4'b1000;
    wstrb_buf[2] = 4'b0000;
    wstrb_buf[3] = 4'b0110;
    send_write(make_ax(2, 'h0300, 3, 2, axi_mem_pkg::BURST_INCR), 1'b0);
    read_burst(make_ax(3, 'h0300, 3, 2, axi_mem_pkg::BURST_INCR), 1'b0);
    // Byte-wide beats with the strobe on their byte lane
    fill_buf(2, 4'hF);
    send_write(make_ax(4, 'h0400, 1, 2, axi_mem_pkg::BURST_INCR), 1'b0);
    ax = make_ax(5, 'h0401, 3, 0, axi_mem_pkg::BURST_INCR);
    fill_buf(4, 4'h0);
    for (int i = 0; i < 4; i++) begin
      a = beat_address(ax, i);
      wstrb_buf[i] = axi_mem_pkg::strb_t'(1) << a[1:0];
    end
    send_write(ax, 1'b0);
    read_burst(make_ax(6, 'h0400, 1, 2, axi_mem_pkg::BURST_INCR), 1'b0);
    end_test();

    start_test("backpressure");
    fill_buf(6, 4'hF);
    send_write(make_ax(9, 'h0500, 5, 2, axi_mem_pkg::BURST_INCR), 1'b1);
    fill_buf(8, 4'hF);
    send_write(make_ax(10, 'h0590, 7, 2, axi_mem_pkg::BURST_WRAP), 1'b1);
    ars[0] = make_ax(1, 'h0500, 5, 2, axi_mem_pkg::BURST_INCR);
    ars[1] = make_ax(2, 'h0590, 7, 2, axi_mem_pkg::BURST_WRAP);
    ars[2] = make_ax(3, 'h0040, 7, 2, axi_mem_pkg::BURST_INCR);
    // Queue all three before taking any R beat
    for (int i = 0; i < 3; i++) begin
      send_ar(ars[i]);
    end
    for (int i = 0; i < 3; i++) begin
      collect_r(ars[i], 1'b1);
    end
    // Every burst is done, so no further R beat or B may show up
    repeat (3) @(negedge clk);
    if (axi_rsp.r_valid || axi_rsp.b_valid) begin
      errors = errors + 1;
      $display("%s: an extra R beat or B appeared after the last burst", cur_test);
    end
    end_test();

    $display("%0d tests run, %0d with errors, %0d check errors", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the DUT stopped responding", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+src
src/axi_mem_pkg.sv
src/axi_beat_addr.sv
src/axi_addr_fifo.sv
src/axi_mem_array.sv
src/axi_mem_write.sv
src/axi_mem_read.sv
src/axi_mem_top.sv
verif/tb_axi_mem.sv

// File: Makefile
TOP := tb_axi_mem
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module axi_mem_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "^tests failed$$" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "^all tests passed$$" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
